// ==== filelist.f ====
+incdir+verif
logic/cpu_pkg.sv
logic/alu.sv
logic/control_unit.sv
logic/register_bank.sv
logic/acc_cpu.sv
verif/tb_acc_cpu.sv

// ==== logic/acc_cpu.sv ====
module acc_cpu #(
    parameter int ADDR_W = 10
) (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic [cpu_pkg::DATA_W-1:0]  im_data,
    input  logic [cpu_pkg::DATA_W-1:0]  dm_rdata,
    output logic [ADDR_W-1:0]           im_addr,
    output logic [ADDR_W-1:0]           dm_addr,
    output logic [cpu_pkg::DATA_W-1:0]  dm_wdata,
    output logic                        dm_we,
    output logic                        halted
);
    import cpu_pkg::*;

    ctrl_word_t        ctrl;
    opcode_t           opcode;
    logic              z;
    logic [DATA_W-1:0] alu_a;
    logic [DATA_W-1:0] alu_b;
    logic [DATA_W-1:0] alu_y;

    control_unit u_control_unit (
        .clk    (clk),
        .arst_n (arst_n),
        .opcode (opcode),
        .z      (z),
        .ctrl   (ctrl),
        .halted (halted)
    );

    alu u_alu (
        .alu_op (ctrl.alu_op),
        .a      (alu_a),
        .b      (alu_b),
        .y      (alu_y)
    );

    register_bank #(
        .ADDR_W (ADDR_W)
    ) u_register_bank (
        .clk      (clk),
        .arst_n   (arst_n),
        .ctrl     (ctrl),
        .alu_y    (alu_y),
        .im_data  (im_data),
        .dm_rdata (dm_rdata),
        .opcode   (opcode),
        .z        (z),
        .alu_a    (alu_a),
        .alu_b    (alu_b),
        .im_addr  (im_addr),
        .dm_addr  (dm_addr),
        .dm_wdata (dm_wdata),
        .dm_we    (dm_we)
    );

endmodule

// ==== logic/alu.sv ====
module alu (
    input  cpu_pkg::alu_op_t            alu_op,
    input  logic [cpu_pkg::DATA_W-1:0]  a,
    input  logic [cpu_pkg::DATA_W-1:0]  b,
    output logic [cpu_pkg::DATA_W-1:0]  y
);
    import cpu_pkg::*;

    logic [2*DATA_W-1:0] product;

    assign product = a * b;

    always_comb begin
        case (alu_op)
            alu_add: begin
                y = a + b;
            end
            alu_sub: begin
                y = a - b;
            end
            alu_mult: begin
                y = product[DATA_W-1:0];   // low half only
            end
            alu_lshift: begin
                y = {a[DATA_W-2:0], 1'b0};
            end
            default: begin
                y = a;   // pass AC through
            end
        endcase
    end

endmodule

// ==== logic/control_unit.sv ====
module control_unit (
    input  logic                clk,
    input  logic                arst_n,
    input  cpu_pkg::opcode_t    opcode,
    input  logic                z,
    output cpu_pkg::ctrl_word_t ctrl,
    output logic                halted
);
    import cpu_pkg::*;

    state_t state;
    state_t next_state;

    // first execute state of each instruction
    function automatic state_t exec_state(input opcode_t op);
        state_t s;
        case (op)
            op_ldac:   s = st_ldac1;
            op_ldiac:  s = st_ldiac1;
            op_stac:   s = st_stac1;
            op_mvacar,
            op_mvacr,
            op_mvacr1,
            op_mvacr2,
            op_mvacr3,
            op_mvacr4,
            op_mvr1ac,
            op_mvr2ac,
            op_mvr3ac,
            op_mvr4ac: s = st_move;
            op_add,
            op_sub,
            op_mult,
            op_lshift: s = st_alu;
            op_inac:   s = st_inac;
            op_clac:   s = st_clac;
            op_jpnz:   s = st_jpnz;
            op_endop:  s = st_end;
            default:   s = st_nop;   // unknown opcodes too
        endcase
        return s;
    endfunction

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state  <= st_fetch1;
            halted <= 1'b0;
        end else begin
            state  <= next_state;
            halted <= (state == st_end);   // one cycle behind st_end
        end
    end

    always_comb begin
        ctrl       = '0;
        next_state = st_fetch1;
        case (state)
            st_fetch1: begin
                ctrl.bus_src  = bus_im;
                ctrl.write.ir = 1'b1;
                next_state    = st_fetch2;
            end
            st_fetch2: begin
                ctrl.inc.pc = 1'b1;
                next_state  = exec_state(opcode);
            end
            st_ldac1: begin
                ctrl.bus_src  = bus_ac;
                ctrl.write.ar = 1'b1;
                next_state    = st_ldac2;
            end
            st_ldiac1: begin
                ctrl.bus_src  = bus_ir_operand;
                ctrl.write.ar = 1'b1;
                next_state    = st_ldiac2;
            end
            st_ldac2,
            st_ldiac2: begin
                ctrl.bus_src  = bus_dm;
                ctrl.write.ac = 1'b1;
            end
            st_stac1: begin
                ctrl.bus_src  = bus_ac;
                ctrl.write.dm = 1'b1;
            end
            st_move: begin
                case (opcode)
                    op_mvacar: ctrl.write.ar = 1'b1;
                    op_mvacr:  ctrl.write.r  = 1'b1;
                    op_mvacr1: ctrl.write.r1 = 1'b1;
                    op_mvacr2: ctrl.write.r2 = 1'b1;
                    op_mvacr3: ctrl.write.r3 = 1'b1;
                    op_mvacr4: ctrl.write.r4 = 1'b1;
                    default:   ctrl.write.ac = 1'b1;   // mvrNac
                endcase
                case (opcode)
                    op_mvr1ac: ctrl.bus_src = bus_r1;
                    op_mvr2ac: ctrl.bus_src = bus_r2;
                    op_mvr3ac: ctrl.bus_src = bus_r3;
                    op_mvr4ac: ctrl.bus_src = bus_r4;
                    default:   ctrl.bus_src = bus_ac;
                endcase
            end
            st_alu: begin
                ctrl.write.ac_from_alu = 1'b1;
                case (opcode)
                    op_add:    ctrl.alu_op = alu_add;
                    op_sub:    ctrl.alu_op = alu_sub;
                    op_mult:   ctrl.alu_op = alu_mult;
                    op_lshift: ctrl.alu_op = alu_lshift;
                    default:   ctrl.alu_op = alu_none;
                endcase
            end
            st_inac: begin
                ctrl.inc.ac = 1'b1;
            end
            st_clac: begin
                ctrl.clr.ac = 1'b1;
            end
            st_jpnz: begin
                if (!z) begin
                    ctrl.bus_src  = bus_ir_operand;
                    ctrl.write.pc = 1'b1;
                end
            end
            st_end: begin
                next_state = st_end;   // only reset leaves
            end
            default: begin
                next_state = st_fetch1;   // st_nop
            end
        endcase
    end

endmodule

// ==== logic/cpu_pkg.sv ====
package cpu_pkg;

    localparam int DATA_W = 16;
    localparam int OPC_W  = 6;   // upper bits of an instruction

    typedef enum logic [OPC_W-1:0] {
        op_nop,
        op_ldac,     // AC <- DM[AC]
        op_ldiac,    // AC <- DM[operand]
        op_stac,     // DM[AR] <- AC
        op_mvacar,
        op_mvacr,
        op_mvacr1,
        op_mvacr2,
        op_mvacr3,
        op_mvacr4,
        op_mvr1ac,
        op_mvr2ac,
        op_mvr3ac,
        op_mvr4ac,
        op_add,
        op_sub,
        op_mult,
        op_lshift,
        op_inac,
        op_clac,
        op_jpnz,     // PC <- operand when AC != 0
        op_endop
    } opcode_t;

    typedef enum logic [4:0] {
        st_fetch1, st_fetch2,
        st_ldac1, st_ldac2,
        st_ldiac1, st_ldiac2,
        st_stac1,
        st_move, st_alu, st_inac, st_clac,
        st_jpnz, st_nop, st_end
    } state_t;

    typedef enum logic [2:0] {
        alu_none, alu_add, alu_sub, alu_mult, alu_lshift
    } alu_op_t;

    typedef enum logic [3:0] {
        bus_none, bus_ir_operand, bus_ac, bus_r,
        bus_r1, bus_r2, bus_r3, bus_r4,
        bus_dm, bus_im
    } bus_src_t;

    typedef struct packed {
        logic pc;
        logic ir;
        logic ar;
        logic ac;
        logic r;
        logic r1;
        logic r2;
        logic r3;
        logic r4;
        logic dm;
        logic ac_from_alu;
    } reg_mask_t;

    typedef struct packed {
        bus_src_t  bus_src;
        reg_mask_t write;
        reg_mask_t inc;
        reg_mask_t clr;
        alu_op_t   alu_op;
    } ctrl_word_t;

endpackage

// ==== logic/register_bank.sv ====
module register_bank #(
    parameter int ADDR_W = 10
) (
    input  logic                        clk,
    input  logic                        arst_n,
    input  cpu_pkg::ctrl_word_t         ctrl,
    input  logic [cpu_pkg::DATA_W-1:0]  alu_y,
    input  logic [cpu_pkg::DATA_W-1:0]  im_data,
    input  logic [cpu_pkg::DATA_W-1:0]  dm_rdata,
    output cpu_pkg::opcode_t            opcode,
    output logic                        z,
    output logic [cpu_pkg::DATA_W-1:0]  alu_a,
    output logic [cpu_pkg::DATA_W-1:0]  alu_b,
    output logic [ADDR_W-1:0]           im_addr,
    output logic [ADDR_W-1:0]           dm_addr,
    output logic [cpu_pkg::DATA_W-1:0]  dm_wdata,
    output logic                        dm_we
);
    import cpu_pkg::*;

    localparam int OPND_W = DATA_W - OPC_W;

    logic [ADDR_W-1:0] pc;
    logic [ADDR_W-1:0] ar;
    logic [DATA_W-1:0] ir;
    logic [DATA_W-1:0] ac;
    logic [DATA_W-1:0] r;
    logic [DATA_W-1:0] gpr [4];   // R1..R4
    logic [3:0]        gpr_we;
    logic [DATA_W-1:0] bus;

    assign gpr_we = {ctrl.write.r4, ctrl.write.r3, ctrl.write.r2, ctrl.write.r1};

    // single internal bus
    always_comb begin
        case (ctrl.bus_src)
            bus_ir_operand: bus = {{OPC_W{1'b0}}, ir[OPND_W-1:0]};
            bus_ac:         bus = ac;
            bus_r:          bus = r;
            bus_r1:         bus = gpr[0];
            bus_r2:         bus = gpr[1];
            bus_r3:         bus = gpr[2];
            bus_r4:         bus = gpr[3];
            bus_dm:         bus = dm_rdata;
            bus_im:         bus = im_data;
            default:        bus = '0;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc <= '0;
            ar <= '0;
            ir <= '0;
            r  <= '0;
        end else begin
            if (ctrl.clr.pc) begin
                pc <= '0;
            end else if (ctrl.write.pc) begin
                pc <= bus[ADDR_W-1:0];   // jump target
            end else if (ctrl.inc.pc) begin
                pc <= pc + 1'b1;
            end
            if (ctrl.write.ar) begin
                ar <= bus[ADDR_W-1:0];
            end
            if (ctrl.write.ir) begin
                ir <= bus;
            end
            if (ctrl.write.r) begin
                r <= bus;
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ac <= '0;
        end else if (ctrl.clr.ac) begin
            ac <= '0;
        end else if (ctrl.write.ac_from_alu) begin
            ac <= alu_y;
        end else if (ctrl.write.ac) begin
            ac <= bus;
        end else if (ctrl.inc.ac) begin
            ac <= ac + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < 4; i++) begin
                gpr[i] <= '0;
            end
        end else begin
            for (int i = 0; i < 4; i++) begin
                if (gpr_we[i]) begin
                    gpr[i] <= bus;
                end
            end
        end
    end

    assign opcode   = opcode_t'(ir[DATA_W-1 -: OPC_W]);
    assign z        = (ac == '0);
    assign alu_a    = ac;
    assign alu_b    = r;
    assign im_addr  = pc;
    assign dm_addr  = ar;
    assign dm_wdata = ac;
    assign dm_we    = ctrl.write.dm;   // write on the next rising edge

endmodule

// ==== verif/acc_cpu_tests.svh ====
function automatic logic [DATA_W-1:0] instr(input opcode_t op, input int operand);
    logic [DATA_W-1:0] w;
    w = {op, operand[DATA_W-OPC_W-1:0]};
    return w;
endfunction

function automatic logic next_bit();
    logic b;
    b = lfsr[0];
    lfsr = lfsr >> 1;
    if (b) begin
        lfsr = lfsr ^ 32'h8020_0003;   // taps 32 22 2 1
    end
    return b;
endfunction

function automatic logic [DATA_W-1:0] rand_bits(input int n);
    logic [DATA_W-1:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
        v = {v[DATA_W-2:0], next_bit()};
    end
    return v;
endfunction

task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else begin
        $display("FAIL %s: expected 0x%0h, got 0x%0h", name, exp, act);
        errors++;
    end
endtask

task automatic expect_write(input logic [ADDR_W-1:0] a, input logic [DATA_W-1:0] d);
    exp_addr.push_back(a);
    exp_data.push_back(d);
endtask

task automatic load_program(input logic [DATA_W-1:0] prog [$]);
    for (int i = 0; i < 1024; i++) begin
        im_mem[i] = instr(op_endop, i);   // a stray jump still halts
        dm_mem[i] = {i[5:0], i[9:0]} ^ 16'h5a5a;
    end
    foreach (prog[i]) begin
        im_mem[i] = prog[i];
    end
    exp_addr.delete();
    exp_data.delete();
endtask

task automatic apply_reset();
    @(negedge clk);
    arst_n = 1'b0;
    repeat (RESET_CYC) begin
        @(negedge clk);
        check_eq("halted", 0, halted);
        check_eq("dm_we", 0, dm_we);
        check_eq("im_addr", 0, im_addr);
    end
    wr_addr.delete();
    wr_data.delete();
    arst_n = 1'b1;
endtask

task automatic run_program();
    apply_reset();
    @(negedge clk);
    while (!halted) begin
        @(negedge clk);
    end
    check_eq("dm write count", exp_addr.size(), wr_addr.size());
    foreach (exp_addr[i]) begin
        if (i < wr_addr.size()) begin
            check_eq($sformatf("dm_addr of write %0d", i), exp_addr[i], wr_addr[i]);
            check_eq($sformatf("dm_wdata of write %0d", i), exp_data[i], wr_data[i]);
        end
    end
endtask

task automatic end_test(input string name, input int errors_before);
    if (errors == errors_before) begin
        $display("%-12s ok", name);
    end else begin
        $display("%-12s %0d error(s)", name, errors - errors_before);
        tests_failed++;
    end
endtask

task automatic test_reset();
    logic [DATA_W-1:0] p [$];
    int e0;
    e0 = errors;
    p = '{instr(op_endop, 0)};
    load_program(p);
    apply_reset();
    @(negedge clk);   // first cycle out of reset
    check_eq("halted", 0, halted);
    check_eq("dm_we", 0, dm_we);
    check_eq("im_addr", 0, im_addr);
    end_test("reset", e0);
endtask

task automatic test_load_store();
    logic [DATA_W-1:0] p [$];
    logic [ADDR_W-1:0] dst;
    logic [ADDR_W-1:0] ptr;
    logic [DATA_W-1:0] d1;
    logic [DATA_W-1:0] d2;
    int e0;
    e0 = errors;
    p = '{instr(op_ldiac, 'h102), instr(op_mvacr1, 0), instr(op_ldiac, 'h100),
          instr(op_mvacar, 0), instr(op_mvr1ac, 0), instr(op_stac, 0),
          instr(op_ldiac, 'h101), instr(op_ldac, 0), instr(op_stac, 0),
          instr(op_endop, 0)};
    load_program(p);
    dst = ADDR_W'(rand_bits(8)) | 10'h300;
    ptr = ADDR_W'(rand_bits(8)) | 10'h200;
    d1  = rand_bits(16);
    d2  = rand_bits(16);
    dm_mem['h100] = DATA_W'(dst);
    dm_mem['h101] = DATA_W'(ptr);
    dm_mem['h102] = d1;
    dm_mem[ptr]   = d2;
    expect_write(dst, d1);
    expect_write(ptr, d2);   // ldac leaves AR at the pointer
    run_program();
    end_test("load_store", e0);
endtask

task automatic test_moves_alu();
    logic [DATA_W-1:0] p [$];
    logic [DATA_W-1:0] a;
    logic [DATA_W-1:0] b;
    int e0;
    e0 = errors;
    p = '{instr(op_ldiac, 'h010), instr(op_mvacr1, 0), instr(op_mvacr, 0),
          instr(op_ldiac, 'h011), instr(op_mvacr2, 0), instr(op_ldiac, 'h012),
          instr(op_mvacar, 0), instr(op_mvr2ac, 0), instr(op_add, 0),
          instr(op_stac, 0),
          instr(op_mvr2ac, 0), instr(op_sub, 0), instr(op_stac, 0),
          instr(op_mvr2ac, 0), instr(op_mult, 0), instr(op_stac, 0),
          instr(op_mvr2ac, 0), instr(op_lshift, 0), instr(op_stac, 0),
          instr(op_mvacr3, 0), instr(op_mvr1ac, 0), instr(op_mvacr4, 0),
          instr(op_mvr3ac, 0), instr(op_stac, 0), instr(op_mvr4ac, 0),
          instr(op_stac, 0), instr(op_endop, 0)};
    load_program(p);
    a = rand_bits(16);
    b = rand_bits(16);
    dm_mem['h010] = a;   // R and R1
    dm_mem['h011] = b;   // R2
    dm_mem['h012] = 16'h0040;
    expect_write(10'h040, b + a);
    expect_write(10'h040, b - a);
    expect_write(10'h040, b * a);
    expect_write(10'h040, b << 1);
    expect_write(10'h040, b << 1);
    expect_write(10'h040, a);
    run_program();
    end_test("moves_alu", e0);
endtask

task automatic test_loop();
    logic [DATA_W-1:0] p [$];
    logic [DATA_W-1:0] n;
    int e0;
    e0 = errors;
    p = '{instr(op_ldiac, 'h021), instr(op_mvacr1, 0), instr(op_clac, 0),
          instr(op_inac, 0), instr(op_mvacr, 0), instr(op_ldiac, 'h020),
          instr(op_mvacar, 0), instr(op_mvr1ac, 0), instr(op_stac, 0),
          instr(op_sub, 0), instr(op_jpnz, 8), instr(op_inac, 0),
          instr(op_stac, 0), instr(op_endop, 0)};
    load_program(p);
    n = rand_bits(3) + 1'b1;   // 1 to 8 passes
    dm_mem['h020] = 16'h0050;
    dm_mem['h021] = n;
    for (int k = int'(n); k >= 1; k--) begin
        expect_write(10'h050, DATA_W'(k));
    end
    expect_write(10'h050, 16'h0001);
    run_program();
    end_test("loop", e0);
endtask

task automatic test_halt();
    logic [DATA_W-1:0] p [$];
    int e0;
    e0 = errors;
    p = '{instr(op_clac, 0), instr(op_inac, 0), instr(op_stac, 0), instr(op_endop, 0)};
    load_program(p);
    expect_write(10'h000, 16'h0001);   // AR still zero from reset
    run_program();
    repeat (HOLD_CYC) begin
        @(negedge clk);
        check_eq("halted", 1, halted);
    end
    check_eq("dm write count after halt", 1, wr_addr.size());
    end_test("halt", e0);
endtask

// ==== verif/tb_acc_cpu.sv ====
module tb_acc_cpu;
    timeunit 1ns;
    timeprecision 100ps;
    import cpu_pkg::*;

    localparam int ADDR_W      = 10;
    localparam int RESET_CYC   = 16;
    localparam int HOLD_CYC    = 20;
    localparam int N_INSTR     = 1 + 10 + 27 + 35 + 4;   // loop test at its longest
    localparam int CYCLE_LIMIT = 4 * N_INSTR + 5 * RESET_CYC + HOLD_CYC + 100;

    logic              clk = 1'b0;
    logic              arst_n;
    logic [DATA_W-1:0] im_data;
    logic [DATA_W-1:0] dm_rdata;
    logic [ADDR_W-1:0] im_addr;
    logic [ADDR_W-1:0] dm_addr;
    logic [DATA_W-1:0] dm_wdata;
    logic              dm_we;
    logic              halted;

    logic [DATA_W-1:0] im_mem [1024];
    logic [DATA_W-1:0] dm_mem [1024];
    logic [ADDR_W-1:0] wr_addr [$];    // writes seen on the DM port
    logic [DATA_W-1:0] wr_data [$];
    logic [ADDR_W-1:0] exp_addr [$];
    logic [DATA_W-1:0] exp_data [$];
    logic [31:0]       lfsr;
    int                cycles;
    int                errors;
    int                tests_failed;

    acc_cpu #(.ADDR_W(ADDR_W)) dut (.*);

    always #50 clk = ~clk;

    assign im_data  = im_mem[im_addr];   // combinational read
    assign dm_rdata = dm_mem[dm_addr];

    always @(posedge clk) begin
        if (dm_we) begin
            dm_mem[dm_addr] <= dm_wdata;
            wr_addr.push_back(dm_addr);
            wr_data.push_back(dm_wdata);
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout after %0d cycles, the DUT never reached halt", cycles);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    `include "acc_cpu_tests.svh"

    initial begin
        arst_n       = 1'b0;
        lfsr         = 32'ha4e4_8097;
        cycles       = 0;
        errors       = 0;
        tests_failed = 0;
        test_reset();
        test_load_store();
        test_moves_alu();
        test_loop();
        test_halt();
        $display("5 tests, %0d failed, %0d check errors", tests_failed, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule
